/* tlv_inject.f */
+incdir+sim
hw/tlv_pkg.sv
hw/tlv_in_fifo.sv
hw/tlv_in_decode.sv
hw/tlv_out_queue.sv
hw/tlv_inject_top.sv
sim/tb_tlv_inject.sv

/* sim/tlv_model.svh */
// reference model of the TLV decoder and its random number source
// Galois LFSR, bip2 of a word, and the per-word model task that fills
// the expected output queues and counts the expected error pulses

`ifndef TLV_MODEL_SVH
`define TLV_MODEL_SVH

logic [31:0]           lfsr_state;
logic [7:0]            m_type;
logic [word_num_w-1:0] m_num;
logic                  m_open;
logic                  m_err;
logic                  m_armed;
logic [word_w-1:0]     m_cmd;
int                    exp_pulses;
logic [word_w-1:0]     exp_data [$];
logic [7:0]            exp_type [$];
logic                  exp_sot  [$];
logic                  exp_eot  [$];

// 32 bit Galois LFSR, one step per bit taken, the old lsb is the output bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        b;
  r = '0;
  for (int i = 0; i < n; i++) begin
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'hA300_0000 : 32'h0);
    r = {r[30:0], b};
  end
  return r;
endfunction

// bit 0 is the parity of the even bits, bit 1 of the odd bits
function automatic logic [1:0] bip2_of(input logic [word_w-1:0] d);
  logic [1:0] p;
  p = 2'b00;
  for (int i = 0; i < word_w; i++) p[i % 2] = p[i % 2] ^ d[i];
  return p;
endfunction

task automatic model_reset();
  m_type     = RQE;
  m_num      = '0;
  m_open     = 1'b0;
  m_err      = 1'b0;
  m_armed    = 1'b0;
  m_cmd      = '0;
  exp_pulses = 0;
endtask

task automatic model_word(input logic [word_w-1:0] d, input logic sot, input logic eot,
                          input logic [7:0] id);
  logic              werr;
  logic              hit;
  logic [word_w-1:0] od;
  if (sot) begin
    m_type = d[7:0];
    m_num  = '0;
  end else begin
    m_num = m_num + 1'b1;
  end
  werr = (sot && bip2_of(d) != 2'b00) || (sot ? m_open : !m_open);
  if (werr && !m_err) exp_pulses++;  // only a new error gives a pulse
  m_err  = werr;
  // the frame stays open from a header up to its eot
  if (sot) m_open = !eot;
  else if (eot) m_open = 1'b0;
  od  = d;
  hit = m_armed && (m_type != CMD) && (m_type == m_cmd[20:13]) && (m_num == m_cmd[36:21]);
  if (hit) begin
    od = d ^ (word_w'(m_cmd[47:40]) << (8 * m_cmd[39:37]));
    if (m_cmd[12:10] == single_err) m_armed = 1'b0;
  end
  // word 1 of a CMD TLV, datapath corrupt type, addressed to this block
  if (m_type == CMD && m_num == 1 && d[9:8] == datapath_corrupt && d[7:0] == id) begin
    m_cmd = d;
    if (d[12:10] == single_err || d[12:10] == continuous_err) m_armed = 1'b1;
    else if (d[12:10] == stop) m_armed = 1'b0;
  end
  exp_data.push_back(od);
  exp_type.push_back(m_type);
  exp_sot.push_back(sot);
  exp_eot.push_back(eot);
endtask

`endif

/* sim/tb_tlv_inject.sv */
// testbench for the TLV decoder with fault injection
// random TLV stream with bip2 and framing faults and debug commands,
// random back-pressure, model based output and error pulse checks,
// reset state checks, cycle limit and closing summary

`timescale 1ns/1ps
`default_nettype none

module tb_tlv_inject;
  import tlv_pkg::*;

  localparam int         n_tlv    = 200;
  localparam logic [7:0] strap_id = 8'h5a;

  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  logic                   in_ready;
  logic [word_w-1:0]      in_data;
  logic                   in_sot;
  logic                   in_eot;
  logic [module_id_w-1:0] module_id;
  logic                   out_valid;
  logic                   out_ready;
  logic [word_w-1:0]      out_data;
  tlv_type_e              out_type;
  logic                   out_sot;
  logic                   out_eot;
  logic                   tlv_error;

  logic [word_w-1:0] gen_data [$];
  logic              gen_sot  [$];
  logic              gen_eot  [$];
  int                idx;
  int                accepted;
  int                emitted;
  int                pulse_cnt;
  int                val_errs;
  int                other_errs;
  int                cycles;
  int                cycle_limit;

  `include "tlv_model.svh"

  tlv_inject_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_sot    (in_sot),
    .in_eot    (in_eot),
    .module_id (module_id),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_type  (out_type),
    .out_sot   (out_sot),
    .out_eot   (out_eot),
    .tlv_error (tlv_error)
  );

  always #5 clk = ~clk;

  function automatic logic [word_w-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(32);
    lo = rand_bits(32);
    return {hi, lo};
  endfunction

  function automatic logic [7:0] pick_type();
    logic [2:0] r;
    r = 3'(rand_bits(3));
    return 8'(r % 5);
  endfunction

  // type and length in the low bytes, bits 16 and 17 even out the bip2
  function automatic logic [word_w-1:0] make_header(input logic [7:0] typ, input int len);
    logic [word_w-1:0] d;
    logic [1:0]        p;
    d       = rand_word();
    d[7:0]  = typ;
    d[15:8] = len[7:0];
    p       = bip2_of(d);
    d[16]   = d[16] ^ p[0];
    d[17]   = d[17] ^ p[1];
    return d;
  endfunction

  function automatic logic [word_w-1:0] make_command();
    logic [6:0]  other;
    logic [7:0]  id;
    logic [1:0]  kind;
    logic [1:0]  r;
    logic [2:0]  mode;
    logic [7:0]  tgt;
    logic [31:0] hi;
    logic [31:0] lo;
    other = 7'(rand_bits(7));
    id    = (rand_bits(2) == 0) ? (strap_id ^ {other, 1'b1}) : strap_id;
    kind  = (rand_bits(3) == 0) ? functional_error : datapath_corrupt;
    r     = 2'(rand_bits(2));
    mode  = (r == 2'd3) ? stop : ((r == 2'd2) ? continuous_err : single_err);
    tgt   = pick_type();
    hi    = rand_bits(32);
    lo    = rand_bits(32);
    return {hi[15:0], hi[23:16], lo[2:0], 13'd0, lo[5:3], tgt, mode, kind, id};
  endfunction

  task automatic build_stream();
    logic [7:0]        typ;
    int                len;
    logic [word_w-1:0] d;
    logic              sot;
    for (int t = 0; t < n_tlv; t++) begin
      typ = pick_type();
      len = 1 + rand_bits(3);
      if (typ == CMD && len < 2) len = 2;  // word 1 holds the command
      for (int w = 0; w < len; w++) begin
        if (w == 0) begin
          d = make_header(typ, len);
          if (rand_bits(4) == 0) d[40] = ~d[40];
        end else if (typ == CMD && w == 1) begin
          d = make_command();
        end else begin
          d = rand_word();
        end
        sot = (w == 0);
        if (rand_bits(5) == 0) sot = ~sot;  // missing sot on a header or a doubled sot inside
        gen_data.push_back(d);
        gen_sot.push_back(sot);
        gen_eot.push_back(w == len - 1);
      end
    end
  endtask

  task automatic compare_field(input string name, input logic [word_w-1:0] exp,
                               input logic [word_w-1:0] got);
    assert (got === exp) else begin
      val_errs++;
      $display("[FAIL] %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic report_other(input string what);
    other_errs++;
    $display("error: %s", what);
  endtask

  task automatic check_reset_state();
    compare_field("out_valid", 0, out_valid);
    compare_field("tlv_error", 0, tlv_error);
    compare_field("in_ready", 1, in_ready);
  endtask

  task automatic check_output();
    emitted++;
    assert (exp_data.size() != 0) else report_other("output word arrived with none expected");
    if (exp_data.size() != 0) begin
      compare_field("out_data", exp_data.pop_front(), out_data);
      compare_field("out_type", exp_type.pop_front(), out_type);
      compare_field("out_sot", exp_sot.pop_front(), out_sot);
      compare_field("out_eot", exp_eot.pop_front(), out_eot);
    end
  endtask

  task automatic print_counts();
    $display("summary: %0d value errors, %0d other errors", val_errs, other_errs);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      other_errs++;
      $display("timeout: run not finished after %0d cycles, %0d of %0d words accepted",
               cycles, accepted, gen_data.size());
      print_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    in_sot     = 1'b0;
    in_eot     = 1'b0;
    out_ready  = 1'b0;
    module_id  = strap_id;
    idx        = 0;
    accepted   = 0;
    emitted    = 0;
    pulse_cnt  = 0;
    val_errs   = 0;
    other_errs = 0;
    cycles     = 0;
    lfsr_state = 32'd74;
    model_reset();
    build_stream();
    cycle_limit = 40 * gen_data.size();
    repeat (2) @(posedge clk);
    check_reset_state();
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_state();
    while (idx < gen_data.size() || exp_data.size() != 0) begin
      if (out_valid && out_ready) check_output();
      if (tlv_error) pulse_cnt++;
      if (in_valid && in_ready) begin
        model_word(in_data, in_sot, in_eot, module_id);
        accepted++;
        idx++;
      end
      // a full input queue means at least in_depth words inside the DUT
      assert (in_ready || accepted - emitted >= in_depth)
        else report_other("in_ready dropped while the input queue had room");
      if (idx < gen_data.size() && rand_bits(3) != 0) begin
        in_valid <= 1'b1;
        in_data  <= gen_data[idx];
        in_sot   <= gen_sot[idx];
        in_eot   <= gen_eot[idx];
      end else begin
        in_valid <= 1'b0;
      end
      out_ready <= (rand_bits(2) != 0);
      @(posedge clk);
    end
    compare_field("tlv_error pulses", exp_pulses, pulse_cnt);
    print_counts();
    if (val_errs == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/tlv_inject_top.sv */
// top level of the TLV decoder with fault injection
// input queue, decoder and output queue connected in a chain

`timescale 1ns/1ps
`default_nettype none

module tlv_inject_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [tlv_pkg::word_w-1:0]      in_data,
  input  logic                            in_sot,
  input  logic                            in_eot,
  input  logic [tlv_pkg::module_id_w-1:0] module_id,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [tlv_pkg::word_w-1:0]      out_data,
  output tlv_pkg::tlv_type_e              out_type,
  output logic                            out_sot,
  output logic                            out_eot,
  output logic                            tlv_error
);
  import tlv_pkg::*;

  logic [word_w-1:0] ib_data;
  logic              ib_sot;
  logic              ib_eot;
  logic              ib_empty;
  logic              ib_rd;
  logic              ob_afull;
  logic              dec_valid;
  logic [word_w-1:0] dec_data;
  tlv_type_e         dec_type;
  logic              dec_sot;
  logic              dec_eot;

  tlv_in_fifo u_in_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .in_sot   (in_sot),
    .in_eot   (in_eot),
    .ib_rd    (ib_rd),
    .ib_data  (ib_data),
    .ib_sot   (ib_sot),
    .ib_empty (ib_empty),
    .ib_eot   (ib_eot)
  );

  tlv_in_decode u_in_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .ib_empty  (ib_empty),
    .ib_data   (ib_data),
    .ib_sot    (ib_sot),
    .ib_eot    (ib_eot),
    .ib_rd     (ib_rd),
    .ob_afull  (ob_afull),
    .module_id (module_id),
    .dec_valid (dec_valid),
    .dec_data  (dec_data),
    .dec_type  (dec_type),
    .dec_sot   (dec_sot),
    .dec_eot   (dec_eot),
    .tlv_error (tlv_error)
  );

  tlv_out_queue u_out_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_data  (dec_data),
    .dec_type  (dec_type),
    .dec_sot   (dec_sot),
    .dec_eot   (dec_eot),
    .ob_afull  (ob_afull),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_type  (out_type),
    .out_sot   (out_sot),
    .out_eot   (out_eot)
  );

endmodule

`default_nettype wire

/* hw/tlv_out_queue.sv */
// output word queue between the decoder and the external consumer
// stores data, TLV type and sot/eot per entry
// almost-full keeps room for the words still in the decoder pipeline
// drained with valid/ready, out_valid is not-empty

`timescale 1ns/1ps
`default_nettype none

module tlv_out_queue (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       dec_valid,
  input  logic [tlv_pkg::word_w-1:0] dec_data,
  input  tlv_pkg::tlv_type_e         dec_type,
  input  logic                       dec_sot,
  input  logic                       dec_eot,
  output logic                       ob_afull,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [tlv_pkg::word_w-1:0] out_data,
  output tlv_pkg::tlv_type_e         out_type,
  output logic                       out_sot,
  output logic                       out_eot
);
  import tlv_pkg::*;

  logic [word_w-1:0]    mem_data [out_depth];
  tlv_type_e            mem_type [out_depth];
  logic                 mem_sot  [out_depth];
  logic                 mem_eot  [out_depth];
  logic [out_ptr_w-1:0] wr_ptr;
  logic [out_ptr_w-1:0] rd_ptr;
  logic [out_cnt_w-1:0] count;
  logic [out_cnt_w-1:0] free;
  logic                 pop;

  assign free      = out_cnt_w'(out_depth) - count;
  assign ob_afull  = (free <= out_cnt_w'(out_afull_free));
  assign out_valid = (count != '0);
  assign pop       = out_valid & out_ready;

  assign out_data = mem_data[rd_ptr];
  assign out_type = mem_type[rd_ptr];
  assign out_sot  = mem_sot[rd_ptr];
  assign out_eot  = mem_eot[rd_ptr];

  // the decoder never writes past almost-full, so dec_valid always finds room
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      mem_data[wr_ptr] <= dec_data;
      mem_type[wr_ptr] <= dec_type;
      mem_sot[wr_ptr]  <= dec_sot;
      mem_eot[wr_ptr]  <= dec_eot;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (dec_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({dec_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/tlv_in_decode.sv */
// TLV decoder with debug fault injection, two pipeline stages
// stage 1 captures the word and tracks TLV type and word position
// stage 2 checks framing and header bip2, pulses tlv_error on a new error,
// captures datapath corrupt commands and XORs the targeted word

`timescale 1ns/1ps
`default_nettype none

module tlv_in_decode (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            ib_empty,
  input  logic [tlv_pkg::word_w-1:0]      ib_data,
  input  logic                            ib_sot,
  input  logic                            ib_eot,
  output logic                            ib_rd,
  input  logic                            ob_afull,
  input  logic [tlv_pkg::module_id_w-1:0] module_id,
  output logic                            dec_valid,
  output logic [tlv_pkg::word_w-1:0]      dec_data,
  output tlv_pkg::tlv_type_e              dec_type,
  output logic                            dec_sot,
  output logic                            dec_eot,
  output logic                            tlv_error
);
  import tlv_pkg::*;

  tlv_word_u             ib_word;
  logic                  s1_valid;
  logic [word_w-1:0]     s1_data;
  logic                  s1_sot;
  logic                  s1_eot;
  tlv_type_e             s1_type;
  logic [word_num_w-1:0] s1_word_num;
  tlv_word_u             s1_word;

  logic                  frame_open;
  logic                  word_err;
  logic [1:0]            s1_bip2;
  logic                  bip2_err;
  logic                  frame_err;
  logic                  new_err;

  debug_cmd_t            arm_cmd;
  logic                  armed;
  logic                  cmd_hit;
  logic                  inj_hit;
  logic [word_w-1:0]     inj_mask;

  // output queue almost-full already reserves room for both words in flight
  assign ib_rd = ~ib_empty & ~ob_afull;

  assign ib_word = ib_data;
  assign s1_word = s1_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      s1_type     <= RQE;
      s1_word_num <= '0;
    end else begin
      s1_valid <= ib_rd;
      if (ib_rd) begin
        if (ib_sot) begin
          s1_type     <= ib_word.hdr.tlv_type;
          s1_word_num <= '0;
        end else begin
          s1_word_num <= s1_word_num + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ib_rd) begin
      s1_data <= ib_data;
      s1_sot  <= ib_sot;
      s1_eot  <= ib_eot;
    end
  end

  // bit 0 covers the even bits and bit 1 the odd bits, a good header gives zero
  assign s1_bip2  = {^(s1_data & ~even_bit_msk), ^(s1_data & even_bit_msk)};
  assign bip2_err = s1_sot & (s1_bip2 != 2'b00);

  // a sot word needs a closed frame and any other word needs an open one
  assign frame_err = s1_sot ? frame_open : ~frame_open;
  assign new_err   = bip2_err | frame_err;

  assign cmd_hit = s1_valid &&
                   (s1_type == CMD) &&
                   (s1_word_num == word_num_w'(1)) &&
                   (s1_word.cmd.cmd_type == datapath_corrupt) &&
                   (s1_word.cmd.module_id == module_id);

  assign inj_hit = s1_valid && armed &&
                   (s1_type != CMD) &&
                   (s1_type == arm_cmd.tlv_num) &&
                   (s1_word_num == arm_cmd.word_sel);

  assign inj_mask = {{(word_w - 8){1'b0}}, arm_cmd.byte_msk} << {arm_cmd.byte_off, 3'b000};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid  <= 1'b0;
      frame_open <= 1'b0;
      word_err   <= 1'b0;
      tlv_error  <= 1'b0;
      armed      <= 1'b0;
    end else begin
      dec_valid <= s1_valid;
      tlv_error <= s1_valid & new_err & ~word_err;  // rising edge of the per-word flag
      if (s1_valid) begin
        frame_open <= (s1_sot | frame_open) & ~s1_eot;  // sot with eot is a one-word TLV
        word_err   <= new_err;
      end
      if (cmd_hit) begin
        if (s1_word.cmd.cmd_mode == single_err || s1_word.cmd.cmd_mode == continuous_err) begin
          armed <= 1'b1;
        end else if (s1_word.cmd.cmd_mode == stop) begin
          armed <= 1'b0;
        end
      end else if (inj_hit && arm_cmd.cmd_mode == single_err) begin
        armed <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_hit) arm_cmd <= s1_word.cmd;
    if (s1_valid) begin
      dec_data <= inj_hit ? (s1_data ^ inj_mask) : s1_data;
      dec_type <= s1_type;
      dec_sot  <= s1_sot;
      dec_eot  <= s1_eot;
    end
  end

endmodule

`default_nettype wire

/* hw/tlv_in_fifo.sv */
// input word queue between the external stream and the decoder
// circular buffer of data plus sot/eot flags with pointers and a count
// ready toward the outside is not-full, head entry shown combinationally

`timescale 1ns/1ps
`default_nettype none

module tlv_in_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  logic [tlv_pkg::word_w-1:0] in_data,
  input  logic                       in_sot,
  input  logic                       in_eot,
  input  logic                       ib_rd,
  output logic [tlv_pkg::word_w-1:0] ib_data,
  output logic                       ib_sot,
  output logic                       ib_empty,
  output logic                       ib_eot
);
  import tlv_pkg::*;

  logic [word_w-1:0]   mem_data [in_depth];
  logic                mem_sot  [in_depth];
  logic                mem_eot  [in_depth];
  logic [in_ptr_w-1:0] wr_ptr;
  logic [in_ptr_w-1:0] rd_ptr;
  logic [in_cnt_w-1:0] count;
  logic                push;
  logic                pop;

  assign in_ready = (count != in_cnt_w'(in_depth));
  assign ib_empty = (count == '0);
  assign push     = in_valid & in_ready;
  assign pop      = ib_rd & ~ib_empty;

  assign ib_data = mem_data[rd_ptr];
  assign ib_sot  = mem_sot[rd_ptr];
  assign ib_eot  = mem_eot[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr] <= in_data;
      mem_sot[wr_ptr]  <= in_sot;
      mem_eot[wr_ptr]  <= in_eot;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so the pointer wraps
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/tlv_pkg.sv */
// shared definitions for the TLV decoder with fault injection
// word and counter widths, queue depths and derived pointer widths
// TLV type, debug command type and command mode encodings
// header and debug command views of a data word, and their union

`default_nettype none

package tlv_pkg;

  localparam int word_w         = 64;
  localparam int word_num_w     = 16;
  localparam int module_id_w    = 8;

  localparam int in_depth       = 8;
  localparam int in_ptr_w       = $clog2(in_depth);
  localparam int in_cnt_w       = $clog2(in_depth + 1);

  localparam int out_depth      = 4;
  localparam int out_ptr_w      = $clog2(out_depth);
  localparam int out_cnt_w      = $clog2(out_depth + 1);
  localparam int out_afull_free = 2;  // one free slot per decoder stage

  // selects the even bits of a word, its complement gives the odd bits
  localparam logic [word_w-1:0] even_bit_msk = {(word_w / 2){2'b01}};

  typedef enum logic [7:0] {
    RQE  = 8'd0,
    CMD  = 8'd1,
    DATA = 8'd2,
    KEY  = 8'd3,
    FTR  = 8'd4
  } tlv_type_e;

  typedef enum logic [1:0] {
    datapath_corrupt = 2'd0,
    functional_error = 2'd1
  } cmd_type_e;

  typedef enum logic [2:0] {
    single_err     = 3'd1,
    continuous_err = 3'd2,
    stop           = 3'd3
  } cmd_mode_e;

  typedef struct packed {
    logic [47:0] rsvd;
    logic [7:0]  tlv_len;
    tlv_type_e   tlv_type;  // low byte of the header word
  } tlv_hdr_t;

  typedef struct packed {
    logic [15:0]            rsvd;
    logic [7:0]             byte_msk;
    logic [2:0]             byte_off;
    logic [word_num_w-1:0]  word_sel;
    tlv_type_e              tlv_num;
    cmd_mode_e              cmd_mode;
    cmd_type_e              cmd_type;
    logic [module_id_w-1:0] module_id;
  } debug_cmd_t;

  // header view on sot words, command view on word 1 of a CMD TLV
  typedef union packed {
    tlv_hdr_t   hdr;
    debug_cmd_t cmd;
  } tlv_word_u;

endpackage

`default_nettype wire
